// File: common/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Counter widths
`define HCNT_W 9    // 0..256 plus blank region
`define VCNT_W 10   // Half-line resolution, bit 0 is the phase

// Top three bits of Hcnt loaded when the line enters blank
// 3'b011 puts the counter at 192
`define H_BLANK_START 3'b011

// HS window, compared against Hcnt[5:0] while HB is high
`define HS_ON  6'b010110    // 22
`define HS_OFF 6'b100110    // 38, so HS covers 22..37

// System clocks per pixel
// 20.16 MHz / 4 gives the 5.04 MHz pixel rate
`define CEN_DIV 4

`endif

// File: common/video_pkg.sv
package video_pkg;

    // Raw horizontal count
    // Bit 8 marks the end of the active or blank run
    typedef logic [8:0] hcnt_t;

    // Raw vertical count
    // Bit 0 is the half-line phase, bits 8:1 the visible line
    typedef logic [9:0] vcnt_t;

    // Screen position after flip, H or V
    typedef logic [7:0] scr_pos_t;

    // Timing PROM address, {HB, Hcnt[7:1]}
    typedef logic [7:0] prom_addr_t;

    // Timing PROM nibble
    // Bit 0 and bit 2 shape composite sync, bit 1 advances V
    typedef logic [3:0] prom_data_t;

endpackage

// File: src/pixel_cen_gen.sv
`timescale 1ns/1ns

`include "video_consts.svh"

module pixel_cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,  // Double-pixel rate, object side
    output logic pxl_cen    // Pixel rate
);

    localparam int CNT_W = $clog2(`CEN_DIV);

    // Divider phase
    logic [CNT_W-1:0] cnt;

    // Both enables come out of flops so nothing downstream sees a glitch
    // pxl2_cen high while cnt is odd
    // pxl_cen high on the last phase only, which is also odd
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            if (cnt == CNT_W'(`CEN_DIV - 1)) begin
                cnt <= '0;  // Wrap
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
            pxl2_cen <= ~cnt[0];                          // Next phase is odd
            pxl_cen  <= (cnt == CNT_W'(`CEN_DIV - 2));    // Next phase is the last
        end
    end

endmodule

// File: timing/timing_prom.sv
`timescale 1ns/1ns

module timing_prom
    import video_pkg::*;
(
    input  logic       clk,
    // Read side, from the timing block
    input  prom_addr_t rd_addr,
    output prom_data_t q,
    // Programming side, from the loader
    input  prom_addr_t wr_addr,
    input  logic       we,
    input  prom_data_t din
);

    localparam int DEPTH = 2 ** $bits(prom_addr_t);

    prom_data_t mem [DEPTH];

    // Blank chip until the loader runs
    // All zero means no V strobe, so V stays put
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Registered read, one clk of latency
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

    // Write port is independent of the read address
    // A read of the same word in the same cycle returns the old nibble
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

endmodule

// File: timing/video_timing.sv
`timescale 1ns/1ns

`include "video_consts.svh"

module video_timing
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl2_cen,    // Object pixel runs at twice the rate
    input  logic       pxl_cen,
    input  logic       flip_n,      // Screen flip, active low
    input  prom_data_t prom_data,   // One clk behind prom_addr
    output prom_addr_t prom_addr,
    output scr_pos_t   h,
    output scr_pos_t   v,
    output logic       h2o,
    output logic       hb,
    output logic       hbd_n,       // HB as seen by the object DMA
    output logic       vb,
    output logic       initeo_n,
    output logic       sy_n,        // Composite sync
    output logic       hs,          // Separate syncs for modern monitors
    output logic       vs
);

    logic  flip;
    hcnt_t hcnt;
    hcnt_t hcnt_next;
    vcnt_t vcnt;
    logic  hb_latch;    // HB sampled on every eighth pixel

    // Vertical advance
    logic  vup;
    logic  vup_l;
    logic  vup_edge;

    // Composite sync network, named after the board's gates
    logic  nand_7b_6;
    logic  nand_5b_11;
    logic  nand_7b_8;
    logic  nand_5b_8;
    logic  pre_sy_n;
    logic  vb_sampled;  // FF 6B pin 9
    logic  last_vcnt3;

    assign flip      = ~flip_n;
    assign hcnt_next = hcnt + `HCNT_W'(1);

    // Screen positions
    // Low three H bits never flip, the tile logic needs them as is
    assign h[2:0]   = hcnt[2:0];
    assign h[7:3]   = hcnt[7:3] ^ {5{flip}};
    assign h2o      = hcnt[2] ^ flip;
    assign v        = vcnt[8:1] ^ {8{flip}};    // Drop the half-line bit
    assign initeo_n = ~(flip ^ hb);

    // PROM read address
    assign prom_addr = {hb, hcnt[7:1]};

    // H counter
    // Active run 0..256, then reload to 192 and run to 256 in blank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            hb   <= 1'b0;
        end else if (pxl_cen) begin
            if (!hcnt[8]) begin
                hcnt <= hcnt_next;
            end else begin
                // End of a run, swap between active and blank
                hcnt[8:6] <= hb ? 3'b000 : `H_BLANK_START;
                hcnt[5:0] <= '0;
                hb        <= ~hb;
            end
        end
    end

    // DMA blank
    // HB is taken at the last pixel of each group of eight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb_latch <= 1'b0;
            hbd_n    <= 1'b1;
        end else if (pxl_cen) begin
            if (&hcnt[2:0]) begin
                hb_latch <= hb;
            end
            hbd_n <= ~(hb_latch & hb);  // Low only once both agree
        end
    end

    // V counter
    // Advances on the rising edge of PROM bit 1, seen at pxl2_cen
    assign vup      = prom_data[1];
    assign vup_edge = vup & ~vup_l;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vup_l <= 1'b0;
            vcnt  <= '0;
            vb    <= 1'b0;
        end else if (pxl2_cen) begin
            vup_l <= vup;
            if (vup_edge) begin
                if (vcnt[9] && vcnt[0]) begin
                    vcnt <= '0;     // Frame wrap
                end else begin
                    vcnt <= vcnt + `VCNT_W'(1);
                end
                // VB moves at 32 half-line boundaries only
                if (&vcnt[4:0]) begin
                    vb <= &vcnt[8:6];
                end
            end
        end
    end

    // Composite sync gates
    // Same polarity as on the board, inverted inputs where the chips had them
    assign nand_7b_6  = ~(~vcnt[3] & vcnt[4] & vcnt[5] & vb);  // Vertical sync window
    assign nand_5b_11 = ~(~nand_7b_6 & prom_data[0]);
    assign nand_7b_8  = ~(nand_7b_6 & vb_sampled & prom_data[1]);
    assign nand_5b_8  = ~(~vb_sampled & prom_data[2]);
    assign pre_sy_n   = ~(~nand_5b_11 | ~nand_7b_8 | ~nand_5b_8);

    // Sync outputs, all one clk behind their inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sy_n       <= 1'b1;
            last_vcnt3 <= 1'b0;
            vb_sampled <= 1'b0;
            hs         <= 1'b0;
            vs         <= 1'b0;
        end else begin
            sy_n       <= pre_sy_n;
            last_vcnt3 <= vcnt[3];

            // VB sample on the Vcnt[3] rising edge
            if (vcnt[3] && !last_vcnt3) begin
                vb_sampled <= vb & (&vcnt[8:6]);
            end

            // VS spans the Vcnt[5:4] == 3 band of the blank
            if (vb) begin
                if (vcnt[5:4] == 2'b11) begin
                    vs <= ~vcnt[3];
                end
            end else begin
                vs <= 1'b0;
            end

            // HS window inside HB
            if (hb) begin
                if (hcnt[5:0] == `HS_ON) begin
                    hs <= 1'b1;
                end
                if (hcnt[5:0] == `HS_OFF) begin
                    hs <= 1'b0;
                end
            end else begin
                hs <= 1'b0;     // Never outside blank
            end
        end
    end

endmodule

// File: src/video_timing_top.sv
`timescale 1ns/1ns

module video_timing_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flip_n,
    // PROM programming from the loader
    input  prom_addr_t prog_addr,
    input  logic       prom_we,
    input  prom_data_t prom_din,
    // Video timing
    output logic       pxl_cen,     // For downstream pixel logic
    output scr_pos_t   h,
    output scr_pos_t   v,
    output logic       h2o,
    output logic       hb,
    output logic       hbd_n,
    output logic       vb,
    output logic       initeo_n,
    output logic       sy_n,
    output logic       hs,
    output logic       vs
);

    logic       pxl2_cen;
    prom_addr_t prom_addr;
    prom_data_t prom_data;

    // Clock enables, single clock domain throughout
    pixel_cen_gen u_cen (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    video_timing u_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl2_cen  (pxl2_cen),
        .pxl_cen   (pxl_cen),
        .flip_n    (flip_n),
        .prom_data (prom_data),
        .prom_addr (prom_addr),
        .h         (h),
        .v         (v),
        .h2o       (h2o),
        .hb        (hb),
        .hbd_n     (hbd_n),
        .vb        (vb),
        .initeo_n  (initeo_n),
        .sy_n      (sy_n),
        .hs        (hs),
        .vs        (vs)
    );

    // Timing PROM, 7J on the board
    timing_prom u_prom (
        .clk     (clk),
        .rd_addr (prom_addr),
        .q       (prom_data),
        .wr_addr (prog_addr),
        .we      (prom_we),
        .din     (prom_din)
    );

endmodule

// File: verification/video_timing_tb.sv
`timescale 1ns/1ns

`include "video_consts.svh"

module video_timing_tb
    import video_pkg::*;
();

    localparam int LINE_PXL = 322;                  // 257 active plus 65 blank
    localparam int LINE_CLK = LINE_PXL * `CEN_DIV;

    logic       clk;
    logic       rst_n;
    logic       flip_n;
    prom_addr_t prog_addr;
    logic       prom_we;
    prom_data_t prom_din;
    logic       pxl_cen;
    scr_pos_t   h;
    scr_pos_t   v;
    logic       h2o;
    logic       hb;
    logic       hbd_n;
    logic       vb;
    logic       initeo_n;
    logic       sy_n;
    logic       hs;
    logic       vs;

    // Reference model
    hcnt_t    ref_h;
    logic     ref_hb;
    vcnt_t    ref_vcnt;
    logic     ref_vb;
    logic     hb_d;
    logic     vb_d;
    logic     strobes_on;   // PROM holds the strobe image
    int       line_pxl;     // pxl_cen ticks since last hb rise
    int       line_clk;     // clk edges since last hb rise, the rise edge included
    logic     line_valid;
    int       hs_pxl;       // pxl_cen ticks with hs high in this blank
    int       wraps;
    logic     vb_seen;

    // Sequence controlled checks
    logic     rst_chk;
    logic     hold_chk;
    scr_pos_t held_v;

    int       err_cnt;
    int       tests_run;
    int       tests_failed;

    logic     hb_rise;
    logic     flip;
    scr_pos_t exp_h;
    scr_pos_t exp_v;
    logic     exp_hs;

    assign hb_rise = hb & ~hb_d;
    assign flip    = ~flip_n;
    assign exp_h   = {ref_h[7:3] ^ {5{flip}}, ref_h[2:0]};  // Low bits never flip
    assign exp_v   = ref_vcnt[8:1] ^ {8{flip}};
    assign exp_hs  = ref_hb && (ref_h[5:0] >= `HS_ON) && (ref_h[5:0] < `HS_OFF);

    video_timing_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .flip_n    (flip_n),
        .prog_addr (prog_addr),
        .prom_we   (prom_we),
        .prom_din  (prom_din),
        .pxl_cen   (pxl_cen),
        .h         (h),
        .v         (v),
        .h2o       (h2o),
        .hb        (hb),
        .hbd_n     (hbd_n),
        .vb        (vb),
        .initeo_n  (initeo_n),
        .sy_n      (sy_n),
        .hs        (hs),
        .vs        (vs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    // Line and frame model stepped by the DUT's own enables
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_h      <= '0;
            ref_hb     <= 1'b0;
            ref_vcnt   <= '0;
            ref_vb     <= 1'b0;
            hb_d       <= 1'b0;
            vb_d       <= 1'b0;
            line_pxl   <= 0;
            line_clk   <= 0;
            line_valid <= 1'b0;
            hs_pxl     <= 0;
            wraps      <= 0;
            vb_seen    <= 1'b0;
        end else begin
            hb_d <= hb;
            vb_d <= vb;
            if (vb) begin
                vb_seen <= 1'b1;
            end
            if (pxl_cen) begin
                if (ref_h == 9'd256) begin
                    ref_h  <= ref_hb ? 9'd0 : 9'd192;   // Blank reload or back to active
                    ref_hb <= ~ref_hb;
                end else begin
                    ref_h <= ref_h + 9'd1;
                end
                if (ref_h == 9'd256 && !ref_hb) begin
                    hs_pxl <= 0;                          // New blank period
                end else if (hs) begin
                    hs_pxl <= hs_pxl + 1;
                end
            end
            if (hb_rise) begin
                line_pxl   <= 0;
                line_clk   <= 1;
                line_valid <= 1'b1;
            end else begin
                line_clk <= line_clk + 1;
                if (pxl_cen) begin
                    line_pxl <= line_pxl + 1;
                end
            end
            // One strobe edge per line once the PROM is loaded
            if (hb_rise && strobes_on) begin
                if (ref_vcnt[4:0] == 5'h1f) begin
                    ref_vb <= &ref_vcnt[8:6];
                end
                if (ref_vcnt[9] && ref_vcnt[0]) begin
                    ref_vcnt <= '0;
                    wraps    <= wraps + 1;
                end else begin
                    ref_vcnt <= ref_vcnt + 10'd1;
                end
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        rst_chk |-> (!hb && !vb && !hs && !vs && hbd_n && sy_n))
        else begin
            err_cnt++;
            $display("mismatch at %0t: outputs not in reset state", $time);
        end

    h_pos: assert property (@(posedge clk) disable iff (!rst_n) h == exp_h)
        else begin
            err_cnt++;
            $display("mismatch at %0t: h %0d, expected %0d", $time, $sampled(h),
                $sampled(exp_h));
        end

    h2o_pos: assert property (@(posedge clk) disable iff (!rst_n) h2o == (ref_h[2] ^ flip))
        else begin
            err_cnt++;
            $display("mismatch at %0t: h2o %0b", $time, $sampled(h2o));
        end

    hb_seq: assert property (@(posedge clk) disable iff (!rst_n) hb == ref_hb)
        else begin
            err_cnt++;
            $display("mismatch at %0t: hb %0b, expected %0b", $time, $sampled(hb),
                $sampled(ref_hb));
        end

    line_len: assert property (@(posedge clk) disable iff (!rst_n)
        (hb_rise && line_valid) |-> (line_pxl == LINE_PXL && line_clk == LINE_CLK))
        else begin
            err_cnt++;
            $display("mismatch at %0t: line of %0d pxl_cen and %0d clk, expected %0d and %0d",
                $time, $sampled(line_pxl), $sampled(line_clk), LINE_PXL, LINE_CLK);
        end

    hs_window: assert property (@(posedge clk) disable iff (!rst_n) pxl_cen |-> hs == exp_hs)
        else begin
            err_cnt++;
            $display("mismatch at %0t: hs %0b at count %0d", $time, $sampled(hs),
                $sampled(ref_h));
        end

    hs_in_blank: assert property (@(posedge clk) disable iff (!rst_n) !hb |-> !hs)
        else begin
            err_cnt++;
            $display("mismatch at %0t: hs high outside hb", $time);
        end

    hs_width: assert property (@(posedge clk) disable iff (!rst_n)
        (pxl_cen && ref_hb && ref_h == 9'd256) |-> hs_pxl == 16)
        else begin
            err_cnt++;
            $display("mismatch at %0t: hs lasted %0d pxl_cen", $time, $sampled(hs_pxl));
        end

    v_count: assert property (@(posedge clk) disable iff (!rst_n) hb_rise |-> v == exp_v)
        else begin
            err_cnt++;
            $display("mismatch at %0t: v %0d, expected %0d", $time, $sampled(v),
                $sampled(exp_v));
        end

    vb_rule: assert property (@(posedge clk) disable iff (!rst_n) hb_rise |-> vb == ref_vb)
        else begin
            err_cnt++;
            $display("mismatch at %0t: vb %0b, expected %0b", $time, $sampled(vb),
                $sampled(ref_vb));
        end

    // vs is registered, so it may trail vb by one clk
    vs_in_blank: assert property (@(posedge clk) disable iff (!rst_n) vs |-> (vb || vb_d))
        else begin
            err_cnt++;
            $display("mismatch at %0t: vs high outside vb", $time);
        end

    initeo: assert property (@(posedge clk) disable iff (!rst_n)
        initeo_n == ~(flip ^ ref_hb))
        else begin
            err_cnt++;
            $display("mismatch at %0t: initeo_n %0b", $time, $sampled(initeo_n));
        end

    v_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (hb_rise && hold_chk) |-> v == held_v)
        else begin
            err_cnt++;
            $display("mismatch at %0t: v moved to %0d, held at %0d", $time, $sampled(v),
                $sampled(held_v));
        end

    // Strobe on bit 1 early in blank and sync bits 0 and 2 at line start
    function automatic prom_data_t prom_rule(input prom_addr_t addr);
        logic strobe;
        logic sync;
        strobe = addr[7] && (addr[6:0] >= 7'd96) && (addr[6:0] <= 7'd111);
        sync   = addr[6:0] < 7'd8;
        return {1'b0, sync, strobe, sync};
    endfunction

    task automatic program_prom(input logic blank_image);
        int a;
        for (a = 0; a < 256; a++) begin
            @(posedge clk);
            prog_addr <= prom_addr_t'(a);
            prom_din  <= blank_image ? prom_data_t'(0) : prom_rule(prom_addr_t'(a));
            prom_we   <= 1'b1;
        end
        @(posedge clk);
        prom_we <= 1'b0;
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic wait_lines(input int n);
        int seen;
        int clks;
        seen = 0;
        clks = 0;
        while (seen < n && clks < (n + 2) * LINE_CLK) begin
            @(posedge clk);
            clks++;
            if (hb_rise) begin
                seen++;
            end
        end
        if (seen < n) begin
            abort_run("hb stopped toggling");
        end
    endtask

    task automatic wait_frame_wrap();
        int clks;
        clks = 0;
        while (wraps == 0 && clks < 600 * LINE_CLK) begin
            @(posedge clk);
            clks++;
        end
        if (wraps == 0) begin
            abort_run("vertical count never wrapped");
        end
    endtask

    task automatic wait_hb_fall();
        int clks;
        clks = 0;
        while (!(hb_d && !hb) && clks < 2 * LINE_CLK) begin
            @(posedge clk);
            clks++;
        end
        if (!(hb_d && !hb)) begin
            abort_run("hb never fell");
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int start;
        int flip_delay;
        int i;
        rst_n        = 1'b0;
        flip_n       = 1'b1;
        prog_addr    = '0;
        prom_we      = 1'b0;
        prom_din     = '0;
        strobes_on   = 1'b0;
        rst_chk      = 1'b0;
        hold_chk     = 1'b0;
        held_v       = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h8375));
        flip_delay = 1 + ($urandom % (6 * LINE_CLK));

        // Outputs checked on the last reset cycle
        start = err_cnt;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 2) begin
                rst_chk <= 1'b1;
            end
        end
        rst_n   <= 1'b1;
        rst_chk <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        report_test("reset state", start);

        program_prom(1'b0);     // Done well before the first blank
        strobes_on <= 1'b1;

        start = err_cnt;
        wait_lines(3);
        report_test("horizontal sequence", start);

        start = err_cnt;
        wait_lines(3);
        report_test("hs window", start);

        // Whole frame plus the vb tail after the wrap
        start = err_cnt;
        wait_frame_wrap();
        wait_lines(40);
        vb_went_high: assert (vb_seen) else begin
            err_cnt++;
            $display("vb never went high during the frame");
        end
        report_test("vertical count and blank", start);

        start = err_cnt;
        for (i = 0; i < flip_delay; i++) begin
            @(posedge clk);
        end
        flip_n <= 1'b0;
        wait_lines(4);
        report_test("screen flip", start);

        // Blank image written early in the active run before the next strobe
        start = err_cnt;
        wait_hb_fall();
        strobes_on <= 1'b0;
        program_prom(1'b1);
        @(posedge clk);
        held_v   <= v;
        hold_chk <= 1'b1;
        wait_lines(6);
        hold_chk <= 1'b0;
        report_test("prom reload holds v", start);

        @(posedge clk);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/video_pkg.sv
src/pixel_cen_gen.sv
timing/timing_prom.sv
timing/video_timing.sv
src/video_timing_top.sv
verification/video_timing_tb.sv
